// File: Bender.yml
package:
  name: cache_subsystem

sources:
  - hdl/cache_geom_pkg.sv
  - hdl/cache_bus_pkg.sv
  - hdl/cache_line_store.sv
  - hdl/cache_ctrl.sv
  - hdl/mem_line_seq.sv
  - hdl/cache_subsystem.sv
  - target: test
    files:
      - verification/cache_subsystem_tb.sv

// File: cache_subsystem.f
hdl/cache_geom_pkg.sv
hdl/cache_bus_pkg.sv
hdl/cache_line_store.sv
hdl/cache_ctrl.sv
hdl/mem_line_seq.sv
hdl/cache_subsystem.sv
verification/cache_subsystem_tb.sv

// File: hdl/cache_bus_pkg.sv
package cache_bus_pkg;

    // cpu port operation
    localparam logic op_read  = 1'b0;
    localparam logic op_write = 1'b1;

    // cpu port access size
    localparam logic size_byte = 1'b0;
    localparam logic size_word = 1'b1;

    localparam int words_per_line = 2; // memory words per cache line

endpackage

// File: hdl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   cpu_valid,
    input  logic                                   cpu_op,
    input  logic                                   cpu_size,
    input  logic [31:0]                            cpu_addr,
    input  logic [31:0]                            cpu_wdata,
    output logic                                   cpu_ready,
    output logic [31:0]                            cpu_rdata,
    output logic [cache_geom_pkg::set_bits-1:0]    lookup_set,
    input  logic                                   rd_valid,
    input  logic                                   rd_dirty,
    input  logic [cache_geom_pkg::tag_bits-1:0]    rd_tag,
    input  cache_geom_pkg::line_data_t             rd_data,
    output logic                                   wr_word_en,
    output logic                                   wr_byte_en,
    output logic [cache_geom_pkg::offset_bits-1:0] wr_offset,
    output logic [31:0]                            wr_wdata,
    output logic                                   fill_en,
    output logic [cache_geom_pkg::tag_bits-1:0]    fill_tag,
    output cache_geom_pkg::line_data_t             fill_data,
    output logic                                   xfer_start,
    output logic                                   xfer_write,
    output cache_geom_pkg::cache_addr_t            xfer_addr,
    output cache_geom_pkg::line_data_t             xfer_wdata,
    input  logic                                   xfer_done,
    input  cache_geom_pkg::line_data_t             xfer_rdata
);
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_compare,
        st_write_back,
        st_allocate
    } state_t;

    state_t state_q;
    state_t state_d;

    cache_addr_t req_addr;
    cache_addr_t victim_addr;
    cache_addr_t fill_addr;
    logic        hit;
    logic        victim_dirty;
    logic        wr_hit;

    assign req_addr   = cpu_addr; // held stable by the requester
    assign lookup_set = req_addr.fields.set;

    assign hit          = rd_valid && (rd_tag == req_addr.fields.tag);
    assign victim_dirty = rd_valid && rd_dirty;

    // line aligned addresses for write-back and fill
    always_comb begin
        victim_addr               = req_addr;
        victim_addr.fields.tag    = rd_tag;
        victim_addr.fields.offset = '0;
        fill_addr                 = req_addr;
        fill_addr.fields.offset   = '0;
    end

    assign wr_hit     = (state_q == st_compare) && hit && (cpu_op == op_write);
    assign wr_word_en = wr_hit && (cpu_size == size_word);
    assign wr_byte_en = wr_hit && (cpu_size == size_byte);
    assign wr_offset  = req_addr.fields.offset;
    assign wr_wdata   = cpu_wdata;

    assign cpu_rdata = rd_data[{req_addr.fields.offset[2], 5'b00000} +: 32];

    assign fill_en    = (state_q == st_allocate) && xfer_done;
    assign fill_tag   = req_addr.fields.tag;
    assign fill_data  = xfer_rdata;
    assign xfer_wdata = rd_data; // victim line for the sequencer to latch

    always_comb begin
        state_d    = state_q;
        cpu_ready  = 1'b0;
        xfer_start = 1'b0;
        xfer_write = 1'b0;
        xfer_addr  = fill_addr;
        case (state_q)
            st_idle: begin
                if (cpu_valid) state_d = st_compare;
            end
            st_compare: begin
                if (hit) begin
                    cpu_ready = 1'b1;
                    state_d   = st_idle;
                end else begin
                    xfer_start = 1'b1;
                    if (victim_dirty) begin
                        xfer_write = 1'b1;
                        xfer_addr  = victim_addr;
                        state_d    = st_write_back;
                    end else begin
                        state_d = st_allocate; // clean victim goes straight to fetch
                    end
                end
            end
            st_write_back: begin
                if (xfer_done) begin
                    xfer_start = 1'b1; // fill follows write-back
                    state_d    = st_allocate;
                end
            end
            st_allocate: begin
                if (xfer_done) state_d = st_compare; // retry now hits
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) state_q <= st_idle;
        else     state_q <= state_d;
    end

    // the requester must still be waiting when the answer comes
    a_ready_with_valid: assert property (@(posedge clk) disable iff (rst)
        cpu_ready |-> cpu_valid);

endmodule

// File: hdl/cache_geom_pkg.sv
package cache_geom_pkg;

    localparam int tag_bits    = 21;
    localparam int set_bits    = 8;
    localparam int offset_bits = 3;
    localparam int num_sets    = 256;
    localparam int line_bytes  = 8;

    // tag above set above byte offset
    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [set_bits-1:0]    set;
        logic [offset_bits-1:0] offset;
    } addr_fields_t;

    // flat word or split into cache fields
    typedef union packed {
        logic [31:0]  word;
        addr_fields_t fields;
    } cache_addr_t;

    typedef logic [line_bytes*8-1:0] line_data_t; // byte 0 in low bits

endpackage

// File: hdl/cache_line_store.sv
`timescale 1ns/1ps

module cache_line_store (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [cache_geom_pkg::set_bits-1:0]    lookup_set,
    input  logic                                   wr_word_en,
    input  logic                                   wr_byte_en,
    input  logic [cache_geom_pkg::offset_bits-1:0] wr_offset,
    input  logic [31:0]                            wr_wdata,
    input  logic                                   fill_en,
    input  logic [cache_geom_pkg::tag_bits-1:0]    fill_tag,
    input  cache_geom_pkg::line_data_t             fill_data,
    output logic                                   rd_valid,
    output logic                                   rd_dirty,
    output logic [cache_geom_pkg::tag_bits-1:0]    rd_tag,
    output cache_geom_pkg::line_data_t             rd_data
);
    import cache_geom_pkg::*;

    logic [num_sets-1:0] valid_q;
    logic [num_sets-1:0] dirty_q;
    logic [tag_bits-1:0] tag_mem [num_sets];
    line_data_t          data_mem [num_sets];

    line_data_t                      upd_line;
    logic [$clog2(line_bytes*8)-1:0] word_lsb;
    logic [$clog2(line_bytes*8)-1:0] byte_lsb;

    assign rd_valid = valid_q[lookup_set];
    assign rd_dirty = dirty_q[lookup_set];
    assign rd_tag   = tag_mem[lookup_set];
    assign rd_data  = data_mem[lookup_set];

    assign word_lsb = {wr_offset[2], 5'b00000}; // low or high word
    assign byte_lsb = {wr_offset, 3'b000};

    // merge cpu write into the current line
    always_comb begin
        upd_line = data_mem[lookup_set];
        if (wr_word_en) begin
            upd_line[word_lsb +: 32] = wr_wdata;
        end else if (wr_byte_en) begin
            upd_line[byte_lsb +: 8] = wr_wdata[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_en) begin
            valid_q[lookup_set] <= 1'b1;
            dirty_q[lookup_set] <= 1'b0;
        end else if (wr_word_en || wr_byte_en) begin
            dirty_q[lookup_set] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[lookup_set]  <= fill_tag;
            data_mem[lookup_set] <= fill_data;
        end else if (wr_word_en || wr_byte_en) begin
            data_mem[lookup_set] <= upd_line;
        end
    end

    // hit update and refill come from different controller states
    a_no_write_during_fill: assert property (@(posedge clk) disable iff (rst)
        !((wr_word_en || wr_byte_en) && fill_en));

endmodule

// File: hdl/cache_subsystem.sv
`timescale 1ns/1ps

module cache_subsystem (
    input  logic        clk,
    input  logic        rst,
    input  logic        cpu_valid,
    input  logic        cpu_op,
    input  logic        cpu_size,
    input  logic [31:0] cpu_addr,
    input  logic [31:0] cpu_wdata,
    output logic        cpu_ready,
    output logic [31:0] cpu_rdata,
    output logic        mem_valid,
    output logic        mem_write,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    input  logic        mem_ready,
    input  logic [31:0] mem_rdata
);
    import cache_geom_pkg::*;

    logic [set_bits-1:0]    lookup_set;
    logic                   rd_valid;
    logic                   rd_dirty;
    logic [tag_bits-1:0]    rd_tag;
    line_data_t             rd_data;
    logic                   wr_word_en;
    logic                   wr_byte_en;
    logic [offset_bits-1:0] wr_offset;
    logic [31:0]            wr_wdata;
    logic                   fill_en;
    logic [tag_bits-1:0]    fill_tag;
    line_data_t             fill_data;
    logic                   xfer_start;
    logic                   xfer_write;
    cache_addr_t            xfer_addr;
    line_data_t             xfer_wdata;
    logic                   xfer_done;
    line_data_t             xfer_rdata;

    cache_ctrl i_cache_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cpu_valid  (cpu_valid),
        .cpu_op     (cpu_op),
        .cpu_size   (cpu_size),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_ready  (cpu_ready),
        .cpu_rdata  (cpu_rdata),
        .lookup_set (lookup_set),
        .rd_valid   (rd_valid),
        .rd_dirty   (rd_dirty),
        .rd_tag     (rd_tag),
        .rd_data    (rd_data),
        .wr_word_en (wr_word_en),
        .wr_byte_en (wr_byte_en),
        .wr_offset  (wr_offset),
        .wr_wdata   (wr_wdata),
        .fill_en    (fill_en),
        .fill_tag   (fill_tag),
        .fill_data  (fill_data),
        .xfer_start (xfer_start),
        .xfer_write (xfer_write),
        .xfer_addr  (xfer_addr),
        .xfer_wdata (xfer_wdata),
        .xfer_done  (xfer_done),
        .xfer_rdata (xfer_rdata)
    );

    cache_line_store i_cache_line_store (
        .clk        (clk),
        .rst        (rst),
        .lookup_set (lookup_set),
        .wr_word_en (wr_word_en),
        .wr_byte_en (wr_byte_en),
        .wr_offset  (wr_offset),
        .wr_wdata   (wr_wdata),
        .fill_en    (fill_en),
        .fill_tag   (fill_tag),
        .fill_data  (fill_data),
        .rd_valid   (rd_valid),
        .rd_dirty   (rd_dirty),
        .rd_tag     (rd_tag),
        .rd_data    (rd_data)
    );

    mem_line_seq i_mem_line_seq (
        .clk        (clk),
        .rst        (rst),
        .xfer_start (xfer_start),
        .xfer_write (xfer_write),
        .xfer_addr  (xfer_addr),
        .xfer_wdata (xfer_wdata),
        .xfer_done  (xfer_done),
        .xfer_rdata (xfer_rdata),
        .mem_valid  (mem_valid),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata)
    );

endmodule

// File: hdl/mem_line_seq.sv
`timescale 1ns/1ps

module mem_line_seq (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        xfer_start,
    input  logic                        xfer_write,
    input  cache_geom_pkg::cache_addr_t xfer_addr,
    input  cache_geom_pkg::line_data_t  xfer_wdata,
    output logic                        xfer_done,
    output cache_geom_pkg::line_data_t  xfer_rdata,
    output logic                        mem_valid,
    output logic                        mem_write,
    output logic [31:0]                 mem_addr,
    output logic [31:0]                 mem_wdata,
    input  logic                        mem_ready,
    input  logic [31:0]                 mem_rdata
);
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    logic        busy_q;
    logic        done_q;
    logic        write_q;
    logic        idx_q;     // word within the line
    logic        last_word;
    cache_addr_t line_q;
    cache_addr_t word_addr;
    line_data_t  wdata_q;
    line_data_t  rdata_q;

    assign last_word = (int'(idx_q) == words_per_line - 1);

    always_comb begin
        word_addr               = line_q;
        word_addr.fields.offset = {idx_q, 2'b00};
    end

    assign mem_valid  = busy_q;
    assign mem_write  = write_q;
    assign mem_addr   = word_addr.word;
    assign mem_wdata  = wdata_q[{idx_q, 5'b00000} +: 32];
    assign xfer_done  = done_q;
    assign xfer_rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            write_q <= 1'b0;
            idx_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (xfer_start) begin
                busy_q  <= 1'b1;
                write_q <= xfer_write;
                idx_q   <= 1'b0; // low word first
            end else if (busy_q && mem_ready) begin
                if (last_word) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    idx_q <= idx_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_start) begin
            line_q  <= xfer_addr;
            wdata_q <= xfer_wdata;
        end
        if (busy_q && mem_ready && !write_q) begin
            rdata_q[{idx_q, 5'b00000} +: 32] <= mem_rdata; // gather fill words
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_write)
            && $stable(mem_addr) && $stable(mem_wdata));

    // controller waits for xfer_done before the next strobe
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst)
        xfer_start |-> !busy_q);

endmodule

// File: verification/cache_subsystem_tb.sv
`timescale 1ns/1ps

module cache_subsystem_tb;
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    localparam int n_random    = 300;
    localparam int n_requests  = n_random + 7; // random plus directed
    localparam int cycle_limit = n_requests * 20;
    localparam int mem_size    = 65536; // all test addresses sit below 64 KiB

    logic        clk;
    logic        rst;
    logic        cpu_valid;
    logic        cpu_op;
    logic        cpu_size;
    logic [31:0] cpu_addr;
    logic [31:0] cpu_wdata;
    logic        cpu_ready;
    logic [31:0] cpu_rdata;
    logic        mem_valid;
    logic        mem_write;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic        mem_ready;
    logic [31:0] mem_rdata;

    logic [7:0]          mem_bytes [mem_size];
    logic [7:0]          ref_bytes [mem_size];
    bit                  line_valid [num_sets];
    bit                  line_dirty [num_sets];
    logic [tag_bits-1:0] line_tag [num_sets];
    logic [64:0]         exp_mem_q [$]; // write, addr, data
    logic [32:0]         exp_rsp_q [$]; // is read, data
    logic [32:0]         rsp_entry;

    int          error_count;
    int          check_count;
    int          cycle_count;
    logic [31:0] stim_state;
    logic [31:0] delay_state;
    logic        mem_waiting;
    int          mem_delay;
    logic        hold_write;
    logic [31:0] hold_addr;
    logic [31:0] hold_wdata;

    cache_subsystem i_cache_subsystem (
        .clk       (clk),
        .rst       (rst),
        .cpu_valid (cpu_valid),
        .cpu_op    (cpu_op),
        .cpu_size  (cpu_size),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_ready (cpu_ready),
        .cpu_rdata (cpu_rdata),
        .mem_valid (mem_valid),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_state = xorshift32(stim_state);
        return stim_state;
    endfunction

    // power-up contents mix every address bit
    function automatic logic [7:0] init_byte(input logic [31:0] a);
        logic [31:0] h;
        h = a * 32'h9e3779b1;
        return h[31:24] ^ h[15:8];
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = mem_bytes[16'(a + i)];
        end
        return w;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] a);
        logic [31:0] w;
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = ref_bytes[16'(a + i)];
        end
        return w;
    endfunction

    // applies one cpu request to the flat model and returns the word a read sees
    function automatic logic [31:0] ref_access(input logic op, input logic size,
                                               input logic [31:0] addr,
                                               input logic [31:0] wdata);
        logic [31:0] base;
        base = {addr[31:2], 2'b00};
        if (op == op_write && size == size_word) begin
            for (int i = 0; i < 4; i++) begin
                ref_bytes[16'(base + i)] = wdata[8*i +: 8];
            end
        end else if (op == op_write) begin
            ref_bytes[addr[15:0]] = wdata[7:0];
        end
        return ref_word(base);
    endfunction

    // tag model of the cache that queues the memory words a request should cause
    function automatic bit predict_traffic(input logic op, input cache_addr_t a);
        cache_addr_t line;
        int          s;
        s = a.fields.set;
        if (line_valid[s] && line_tag[s] == a.fields.tag) begin
            if (op == op_write) line_dirty[s] = 1'b1;
            return 1'b1;
        end
        line = a;
        line.fields.offset = '0;
        if (line_valid[s] && line_dirty[s]) begin
            line.fields.tag = line_tag[s]; // victim goes back first
            for (int w = 0; w < words_per_line; w++) begin
                exp_mem_q.push_back({1'b1, 32'(line.word + 4*w), ref_word(line.word + 4*w)});
            end
            line.fields.tag = a.fields.tag;
        end
        for (int w = 0; w < words_per_line; w++) begin
            exp_mem_q.push_back({1'b0, 32'(line.word + 4*w), 32'h0});
        end
        line_valid[s] = 1'b1;
        line_tag[s]   = a.fields.tag;
        line_dirty[s] = (op == op_write);
        return 1'b0;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic serve_memory();
        logic [64:0] want;
        if (exp_mem_q.size() == 0) begin
            error_count++;
            $display("unexpected memory access at %0t, address %h", $time, mem_addr);
        end else begin
            want = exp_mem_q.pop_front();
            check_equal("mem_write", 32'(mem_write), 32'(want[64]));
            check_equal("mem_addr", mem_addr, want[63:32]);
            if (want[64]) check_equal("mem_wdata", mem_wdata, want[31:0]);
        end
        if (mem_write) begin
            for (int i = 0; i < 4; i++) begin
                mem_bytes[16'(mem_addr + i)] = mem_wdata[8*i +: 8];
            end
        end else begin
            mem_rdata = mem_word(mem_addr);
        end
    endtask

    // memory model with 0 to 3 cycles of random delay
    always @(negedge clk) begin
        mem_ready = 1'b0;
        if (rst) begin
            mem_waiting = 1'b0;
        end else if (mem_valid === 1'b1) begin
            if (!mem_waiting) begin
                mem_waiting = 1'b1;
                delay_state = xorshift32(delay_state);
                mem_delay   = delay_state[1:0];
                hold_write  = mem_write;
                hold_addr   = mem_addr;
                hold_wdata  = mem_wdata;
            end else begin
                check_equal("mem_write", 32'(mem_write), 32'(hold_write)); // held request
                check_equal("mem_addr", mem_addr, hold_addr);
                if (hold_write) check_equal("mem_wdata", mem_wdata, hold_wdata);
            end
            if (mem_delay == 0) begin
                serve_memory();
                mem_waiting = 1'b0;
                mem_ready   = 1'b1;
            end else begin
                mem_delay--;
            end
        end
    end

    // compares every cpu response with the reference model
    always @(posedge clk) begin
        if (!rst && cpu_ready === 1'b1) begin
            if (exp_rsp_q.size() == 0) begin
                error_count++;
                $display("cpu_ready at %0t with no request outstanding", $time);
            end else begin
                rsp_entry = exp_rsp_q.pop_front();
                if (rsp_entry[32]) check_equal("cpu_rdata", cpu_rdata, rsp_entry[31:0]);
            end
            if (exp_mem_q.size() != 0) begin
                error_count++;
                $display("request at %h done with %0d memory words missing",
                         cpu_addr, exp_mem_q.size());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("errors: %0d of %0d checks", error_count, check_count);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic run_request(input logic op, input logic size, input logic [31:0] addr,
                               input logic [31:0] wdata);
        bit hit;
        int waited;
        hit = predict_traffic(op, addr);
        exp_rsp_q.push_back({op == op_read, ref_access(op, size, addr, wdata)});
        cpu_valid = 1'b1;
        cpu_op    = op;
        cpu_size  = size;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        waited    = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (cpu_ready !== 1'b1);
        if (hit) check_equal("hit latency", 32'(waited), 32'd2);
        @(negedge clk);
        cpu_valid = 1'b0;
    endtask

    // three tags over four sets keep lines evicting each other
    task automatic random_request();
        logic [31:0] r;
        cache_addr_t a;
        logic        op;
        logic        size;
        r = next_stim();
        a.word          = '0;
        a.fields.tag    = (r[1:0] == 2'd0) ? 21'h05 : (r[1:0] == 2'd1) ? 21'h15 : 21'h0a;
        a.fields.set    = {r[3:2], 6'h11};
        a.fields.offset = r[6:4];
        op   = r[7];
        size = r[8];
        if (op == op_write && size == size_word) a.fields.offset[1:0] = 2'b00;
        run_request(op, size, a.word, next_stim());
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        cpu_valid   = 1'b0;
        cpu_op      = op_read;
        cpu_size    = size_word;
        cpu_addr    = '0;
        cpu_wdata   = '0;
        mem_ready   = 1'b0;
        mem_rdata   = '0;
        error_count = 0;
        check_count = 0;
        cycle_count = 0;
        stim_state  = 32'hc77a;
        delay_state = 32'hc77a;
        mem_waiting = 1'b0;
        mem_delay   = 0;
        for (int i = 0; i < mem_size; i++) begin
            mem_bytes[i] = init_byte(i);
            ref_bytes[i] = init_byte(i);
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // cold miss, hit, word and byte writes, then dirty and clean eviction
        run_request(op_read, size_word, 32'h0000_2a24, 32'h0);
        run_request(op_read, size_word, 32'h0000_2a24, 32'h0);
        run_request(op_write, size_word, 32'h0000_2a20, 32'hcafe_f00d);
        run_request(op_write, size_byte, 32'h0000_2a26, 32'h0000_005a);
        run_request(op_read, size_word, 32'h0000_2a20, 32'h0);
        run_request(op_read, size_word, 32'h0000_aa20, 32'h0); // same set, other tag
        run_request(op_read, size_word, 32'h0000_2a24, 32'h0); // line back from memory

        repeat (n_random) random_request();
        repeat (2) @(negedge clk);

        $display("errors: %0d of %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
